// ==== project.f ====
rtl/fetch_pkg.sv
rtl/fetch_stage.sv
rtl/inst_mem.sv
rtl/decode_stage.sv
rtl/fetch_top.sv
sim/tb_clock.sv
sim/tb_top.sv

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       flush,
    input  logic                       if_valid,
    input  logic [fetch_pkg::xlen-1:0] if_pc,
    input  logic [fetch_pkg::xlen-1:0] if_inst,
    input  logic                       if_adef,
    output logic                       id_allowin,
    output logic                       br_taken,
    output logic [fetch_pkg::xlen-1:0] br_target,
    output logic                       out_valid,
    output logic [fetch_pkg::xlen-1:0] out_pc,
    output logic [fetch_pkg::xlen-1:0] out_inst,
    output logic                       out_adef,
    input  logic                       out_ready
);

    logic        out_fire;
    logic        is_branch;
    logic [25:0] offs26;

    assign id_allowin = ~out_valid | out_ready;
    assign out_fire   = out_valid & out_ready;

    // B offs26, low half of the offset sits in inst[25:10]
    assign offs26    = {out_inst[9:0], out_inst[25:10]};
    assign is_branch = (out_inst[31:26] == fetch_pkg::br_opcode) & ~out_adef;

    assign br_taken  = out_fire & is_branch;
    assign br_target = out_pc + {{4{offs26[25]}}, offs26, 2'b00};

    // the word entering behind a taken branch is off the path
    always_ff @(posedge clk) begin
        if (!resetn) begin
            out_valid <= 1'b0;
        end else if (flush | br_taken) begin
            out_valid <= 1'b0;
        end else if (id_allowin) begin
            out_valid <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid & id_allowin) begin
            out_pc   <= if_pc;
            out_inst <= if_inst;
            out_adef <= if_adef;
        end
    end

endmodule

// ==== rtl/fetch_pkg.sv ====
package fetch_pkg;

    // datapath and address width
    localparam int xlen = 32;

    // first fetch address, reached through the starting flush
    localparam logic [xlen-1:0] reset_pc = 32'h1c00_0000;

    // instruction memory geometry
    localparam int mem_words = 1024;
    localparam int mem_aw    = $clog2(mem_words);  // word address bits 11:2

    // B offs26, bits 31:26
    localparam logic [5:0] br_opcode = 6'b010100;

    // apb map: words below apb_lat_addr, delay register at apb_lat_addr
    localparam logic [xlen-1:0] apb_lat_addr = 32'h0000_1000;
    localparam int lat_bits = 2;  // response delay 0..3 extra cycles

endpackage

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       flush,
    input  logic [fetch_pkg::xlen-1:0] excep_entry,
    input  logic                       br_taken,
    input  logic [fetch_pkg::xlen-1:0] br_target,
    input  logic                       id_allowin,
    input  logic                       inst_addr_ok,
    input  logic                       inst_data_ok,
    input  logic [fetch_pkg::xlen-1:0] inst_rdata,
    output logic                       inst_req,
    output logic [fetch_pkg::xlen-1:0] inst_addr,
    output logic                       if_valid,
    output logic [fetch_pkg::xlen-1:0] if_pc,
    output logic [fetch_pkg::xlen-1:0] if_inst,
    output logic                       if_adef
);

    logic [fetch_pkg::xlen-1:0] pc;         // address of last accepted request
    logic                       req_wait;   // request shown last cycle, not accepted
    logic                       wait_stale; // waiting request overtaken by a redirect
    logic [fetch_pkg::xlen-1:0] hold_addr;
    logic                       pre_if_reqed;  // accepted, data not back yet
    logic                       cancel_cnt;    // outstanding request to drop, 0 or 1
    logic                       fetch_idle;

    // held redirect targets, kept until the request goes out
    logic                       flush_reg;
    logic [fetch_pkg::xlen-1:0] excep_entry_reg;
    logic                       br_taken_reg;
    logic [fetch_pkg::xlen-1:0] br_target_reg;

    // second buffer slot behind the IF register
    logic                       pre_if_valid;
    logic [fetch_pkg::xlen-1:0] pre_if_pc;
    logic [fetch_pkg::xlen-1:0] pre_if_ir;
    logic                       pre_if_adef;

    logic                       redirect;
    logic [fetch_pkg::xlen-1:0] pre_pc;
    logic                       pre_pc_adef;
    logic                       good_pending;
    logic [1:0]                 occ;
    logic [1:0]                 occ_after;
    logic                       out_fire;
    logic                       room;
    logic                       fresh_go;
    logic                       adef_go;
    logic                       accept;
    logic                       stale_acc;
    logic                       good_acc;
    logic                       data_good;
    logic                       in_valid;
    logic [fetch_pkg::xlen-1:0] in_pc;
    logic [fetch_pkg::xlen-1:0] in_inst;

    assign redirect = flush | br_taken;

    // redirects never issue in their own cycle, they go through the held regs
    assign pre_pc = flush_reg    ? excep_entry_reg :
                    br_taken_reg ? br_target_reg   :
                                   pc + 32'd4;
    assign pre_pc_adef = pre_pc[1] | pre_pc[0];

    // words held or owed to the fetch stage
    assign good_pending = pre_if_reqed & ~cancel_cnt;
    assign occ          = {1'b0, if_valid} + {1'b0, pre_if_valid} + {1'b0, good_pending};
    assign out_fire     = if_valid & id_allowin;
    assign occ_after    = occ - {1'b0, out_fire};
    assign room         = ~occ_after[1];

    assign fresh_go = ~req_wait & ~redirect & ~fetch_idle & room;
    assign adef_go  = fresh_go & pre_pc_adef;  // bad address, no memory access

    assign inst_req  = req_wait | (fresh_go & ~pre_pc_adef);
    assign inst_addr = req_wait ? hold_addr : pre_pc;

    assign accept    = inst_req & inst_addr_ok;
    assign stale_acc = accept & (wait_stale | redirect);
    assign good_acc  = accept & ~wait_stale & ~redirect;

    // returning word belongs to pc unless it was cancelled
    assign data_good = inst_data_ok & ~cancel_cnt & ~redirect;
    assign in_valid  = data_good | adef_go;
    assign in_pc     = data_good ? pc : pre_pc;
    assign in_inst   = data_good ? inst_rdata : '0;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            req_wait   <= 1'b0;
            wait_stale <= 1'b0;
        end else begin
            req_wait   <= inst_req & ~inst_addr_ok;
            wait_stale <= inst_req & ~inst_addr_ok & (redirect | wait_stale);
        end
    end

    always_ff @(posedge clk) begin
        hold_addr <= inst_addr;  // equals inst_addr while waiting
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc <= fetch_pkg::reset_pc - 32'd4;
        end else if (good_acc) begin
            pc <= inst_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pre_if_reqed <= 1'b0;
        end else if (accept) begin
            pre_if_reqed <= 1'b1;
        end else if (inst_data_ok) begin
            pre_if_reqed <= 1'b0;
        end
    end

    // memory keeps one request in flight, so one bit is enough
    always_ff @(posedge clk) begin
        if (!resetn) begin
            cancel_cnt <= 1'b0;
        end else begin
            cancel_cnt <= (cancel_cnt & ~inst_data_ok)
                        | (redirect & pre_if_reqed & ~inst_data_ok)
                        | stale_acc;
        end
    end

    // idle until the first flush, and again after a misaligned target
    always_ff @(posedge clk) begin
        if (!resetn) begin
            fetch_idle <= 1'b1;
        end else if (flush) begin
            fetch_idle <= 1'b0;
        end else if (adef_go) begin
            fetch_idle <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            flush_reg    <= 1'b0;
            br_taken_reg <= 1'b0;
        end else if (flush) begin
            flush_reg    <= 1'b1;  // flush wins over a branch
            br_taken_reg <= 1'b0;
        end else if (br_taken) begin
            br_taken_reg <= 1'b1;
        end else if (good_acc | adef_go) begin
            flush_reg    <= 1'b0;
            br_taken_reg <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            excep_entry_reg <= excep_entry;
        end
        if (br_taken) begin
            br_target_reg <= br_target;
        end
    end

    // two-entry buffer, IF register at the head
    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_valid     <= 1'b0;
            pre_if_valid <= 1'b0;
        end else if (redirect) begin
            if_valid     <= 1'b0;
            pre_if_valid <= 1'b0;
        end else if (~if_valid | out_fire) begin
            if_valid     <= pre_if_valid | in_valid;
            pre_if_valid <= pre_if_valid & in_valid;
        end else if (in_valid) begin
            pre_if_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (~if_valid | out_fire) begin
            if (pre_if_valid) begin
                if_pc   <= pre_if_pc;
                if_inst <= pre_if_ir;
                if_adef <= pre_if_adef;
            end else begin
                if_pc   <= in_pc;
                if_inst <= in_inst;
                if_adef <= adef_go;
            end
        end
        if (in_valid & (pre_if_valid | (if_valid & ~out_fire))) begin
            pre_if_pc   <= in_pc;
            pre_if_ir   <= in_inst;
            pre_if_adef <= adef_go;
        end
    end

    // a new word always finds a free slot
    a_no_overflow: assert property (@(posedge clk) disable iff (!resetn)
        in_valid |-> !(if_valid && pre_if_valid && !out_fire));

endmodule

// ==== rtl/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       flush,
    input  logic [fetch_pkg::xlen-1:0] excep_entry,
    output logic                       out_valid,
    output logic [fetch_pkg::xlen-1:0] out_pc,
    output logic [fetch_pkg::xlen-1:0] out_inst,
    output logic                       out_adef,
    input  logic                       out_ready,
    input  logic [fetch_pkg::xlen-1:0] paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [fetch_pkg::xlen-1:0] pwdata,
    output logic [fetch_pkg::xlen-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr
);

    // fetch to memory
    logic                       inst_req;
    logic [fetch_pkg::xlen-1:0] inst_addr;
    logic                       inst_addr_ok;
    logic                       inst_data_ok;
    logic [fetch_pkg::xlen-1:0] inst_rdata;

    // fetch to decode and back
    logic                       if_valid;
    logic [fetch_pkg::xlen-1:0] if_pc;
    logic [fetch_pkg::xlen-1:0] if_inst;
    logic                       if_adef;
    logic                       id_allowin;
    logic                       br_taken;
    logic [fetch_pkg::xlen-1:0] br_target;

    fetch_stage fetch_stage_i (
        .clk          (clk),
        .resetn       (resetn),
        .flush        (flush),
        .excep_entry  (excep_entry),
        .br_taken     (br_taken),
        .br_target    (br_target),
        .id_allowin   (id_allowin),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .if_valid     (if_valid),
        .if_pc        (if_pc),
        .if_inst      (if_inst),
        .if_adef      (if_adef)
    );

    inst_mem inst_mem_i (
        .clk          (clk),
        .resetn       (resetn),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata)
    );

    decode_stage decode_stage_i (
        .clk        (clk),
        .resetn     (resetn),
        .flush      (flush),
        .if_valid   (if_valid),
        .if_pc      (if_pc),
        .if_inst    (if_inst),
        .if_adef    (if_adef),
        .id_allowin (id_allowin),
        .br_taken   (br_taken),
        .br_target  (br_target),
        .out_valid  (out_valid),
        .out_pc     (out_pc),
        .out_inst   (out_inst),
        .out_adef   (out_adef),
        .out_ready  (out_ready)
    );

endmodule

// ==== rtl/inst_mem.sv ====
`timescale 1ns/1ps

module inst_mem (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic [fetch_pkg::xlen-1:0] paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [fetch_pkg::xlen-1:0] pwdata,
    output logic [fetch_pkg::xlen-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  logic                       inst_req,
    input  logic [fetch_pkg::xlen-1:0] inst_addr,
    output logic                       inst_addr_ok,
    output logic                       inst_data_ok,
    output logic [fetch_pkg::xlen-1:0] inst_rdata
);

    logic [fetch_pkg::xlen-1:0]     mem [0:fetch_pkg::mem_words-1];
    logic [fetch_pkg::lat_bits-1:0] lat_q;     // extra response cycles
    logic                           pending;
    logic [fetch_pkg::mem_aw-1:0]   word_addr;
    logic [fetch_pkg::lat_bits-1:0] count;

    logic apb_access;
    logic sel_mem;
    logic sel_lat;
    logic accept;

    assign apb_access = psel & penable;
    assign sel_mem    = paddr < fetch_pkg::apb_lat_addr;
    assign sel_lat    = paddr == fetch_pkg::apb_lat_addr;

    // no wait states
    assign pready  = 1'b1;
    assign pslverr = apb_access & ~sel_mem & ~sel_lat;
    assign prdata  = sel_mem ? mem[paddr[fetch_pkg::mem_aw+1:2]] :
                     sel_lat ? {{(fetch_pkg::xlen-fetch_pkg::lat_bits){1'b0}}, lat_q} :
                               '0;

    always_ff @(posedge clk) begin
        if (apb_access & pwrite & sel_mem) begin
            mem[paddr[fetch_pkg::mem_aw+1:2]] <= pwdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            lat_q <= '0;
        end else if (apb_access & pwrite & sel_lat) begin
            lat_q <= pwdata[fetch_pkg::lat_bits-1:0];
        end
    end

    // fetch port, one request at a time
    assign inst_data_ok = pending & (count == '0);
    assign inst_addr_ok = ~pending | inst_data_ok;  // free, or freeing this cycle
    assign accept       = inst_req & inst_addr_ok;
    assign inst_rdata   = mem[word_addr];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (inst_data_ok) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            word_addr <= inst_addr[fetch_pkg::mem_aw+1:2];
            count     <= lat_q;  // delay sampled at acceptance
        end else if (pending && count != '0) begin
            count <= count - (fetch_pkg::lat_bits)'(1);
        end
    end

    // a return always traces back to an acceptance at most 4 cycles earlier
    a_data_owed: assert property (@(posedge clk) disable iff (!resetn)
        inst_data_ok |-> $past(accept, 1) || $past(accept, 2) ||
                         $past(accept, 3) || $past(accept, 4));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_top -f project.f -o tb_top > run.log 2>&1 \
    && ./obj_dir/tb_top >> run.log 2>&1

grep -qxF '** PASS **' run.log && echo "simulation passed" \
    || { echo "simulation failed, see run.log"; exit 1; }

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;  // free running, starts low
    end

endmodule

// ==== sim/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

    localparam int reset_cycles    = 16;
    localparam int n_items         = 3000;  // output transfers to check
    localparam int load_cycles     = reset_cycles + fetch_pkg::mem_words * 8 + 64;
    localparam int watchdog_cycles = n_items * 20 + load_cycles;

    logic        clk;
    logic        resetn;
    logic        flush;
    logic [31:0] excep_entry;
    logic        out_ready;
    logic        out_valid;
    logic [31:0] out_pc;
    logic [31:0] out_inst;
    logic        out_adef;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] lfsr = 32'h3124;
    logic [31:0] image [0:fetch_pkg::mem_words-1];  // reference copy of the memory
    logic [31:0] exp_pc;
    logic        dead = 1'b1;  // misaligned item seen, quiet until next flush
    logic        stall_prev = 1'b0;
    logic [31:0] held_pc;
    logic [31:0] held_inst;
    logic        held_adef;
    int          apb_step = 0;
    int          n_xfer = 0;
    int          value_errors = 0;
    int          proto_errors = 0;
    int          timeouts = 0;

    tb_clock #(.period_ns(10)) clock_i (.clk(clk));

    fetch_top fetch_top_i (.*);

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'hd000_0001 : lfsr >> 1;
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // B offs26 jumps relative to its own pc, everything else falls through
    function automatic logic [31:0] next_pc(input logic [31:0] pc, input logic [31:0] word);
        logic [25:0] offs;
        int          hop;  // signed distance in words
        offs = {word[9:0], word[25:10]};
        hop  = $signed(offs);
        if (word[31:26] == fetch_pkg::br_opcode) begin
            return pc + 32'(hop * 4);
        end
        return pc + 32'd4;
    endfunction

    function automatic logic [31:0] make_word();
        logic [5:0]  offs6;
        logic [25:0] offs;
        if (rand_bits(3) != 32'd0) begin
            return rand_bits(32);
        end
        offs6 = 6'(rand_bits(6));  // short hop, never onto itself
        if (offs6 == 6'd0) begin
            offs6 = 6'd1;
        end
        offs = {{20{offs6[5]}}, offs6};
        return {fetch_pkg::br_opcode, offs[15:0], offs[25:16]};
    endfunction

    task automatic apb_access(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);  // access phase ends here
        if (!pready) begin
            proto_errors++;
            $display("pready was low in an APB access phase");
        end
        rdata = prdata;
        err   = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic load_and_verify();
        logic [31:0] rd;
        logic        err;
        for (int i = 0; i < fetch_pkg::mem_words; i++) begin
            image[i] = make_word();
            apb_access(1'b1, 32'(i * 4), image[i], rd, err);
        end
        for (int i = 0; i < fetch_pkg::mem_words; i++) begin
            apb_access(1'b0, 32'(i * 4), 32'd0, rd, err);
            if (rd != image[i] || err) begin
                value_errors++;
                $display("FAILED prdata word %0d: expected %h, got %h, pslverr %h",
                         i, image[i], rd, err);
            end
        end
        apb_access(1'b1, fetch_pkg::apb_lat_addr, 32'd3, rd, err);
        apb_access(1'b0, fetch_pkg::apb_lat_addr, 32'd0, rd, err);
        if (rd != 32'd3) begin
            value_errors++;
            $display("FAILED prdata delay register: expected %h, got %h", 32'd3, rd);
        end
        apb_access(1'b1, fetch_pkg::apb_lat_addr, 32'd0, rd, err);
        apb_access(1'b0, fetch_pkg::apb_lat_addr + 32'h10, 32'd0, rd, err);  // off the map
        if (!err) begin
            value_errors++;
            $display("FAILED pslverr: expected %h, got %h", 1'b1, err);
        end
    endtask

    task automatic check_cycle();
        logic [31:0] want_inst;
        logic        want_adef;
        if (stall_prev && !out_valid) begin
            proto_errors++;
            $display("out_valid dropped while the output waited for out_ready");
        end else if (stall_prev && (out_pc != held_pc || out_inst != held_inst
                                    || out_adef != held_adef)) begin
            value_errors++;
            $display("FAILED out_pc/out_inst/out_adef held: expected %h %h %h, got %h %h %h",
                     held_pc, held_inst, held_adef, out_pc, out_inst, out_adef);
        end
        want_adef = exp_pc[1:0] != 2'b00;
        want_inst = want_adef ? 32'd0 : image[exp_pc[fetch_pkg::mem_aw+1:2]];
        if (dead && out_valid) begin
            proto_errors++;
            $display("out_valid high after a misaligned fetch with no new flush");
        end else if (out_valid && out_ready) begin
            n_xfer++;
            if (out_pc != exp_pc) begin
                value_errors++;
                $display("FAILED out_pc: expected %h, got %h", exp_pc, out_pc);
            end
            if (out_inst != want_inst) begin
                value_errors++;
                $display("FAILED out_inst: expected %h, got %h", want_inst, out_inst);
            end
            if (out_adef != want_adef) begin
                value_errors++;
                $display("FAILED out_adef: expected %h, got %h", want_adef, out_adef);
            end
            dead   = want_adef;
            exp_pc = next_pc(exp_pc, want_inst);
        end
        stall_prev = out_valid && !out_ready && !flush;
        held_pc    = out_pc;
        held_inst  = out_inst;
        held_adef  = out_adef;
        if (flush) begin  // flush beats the branch rule
            exp_pc = excep_entry;
            dead   = 1'b0;
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] target;
        out_ready <= rand_bits(2) != 32'd0;  // ready three cycles in four
        if (flush) begin
            flush <= 1'b0;
        end else if (rand_bits(dead ? 3 : 6) == 32'd0) begin
            target = rand_bits(30) << 2;
            if (rand_bits(2) == 32'd0) begin
                target[1:0] = 2'(rand_bits(2) % 3) + 2'd1;  // misaligned entry
            end
            flush       <= 1'b1;
            excep_entry <= target;
        end
        case (apb_step)
            0: begin
                if (rand_bits(5) == 32'd0) begin  // new response delay now and then
                    psel     <= 1'b1;
                    pwrite   <= 1'b1;
                    paddr    <= fetch_pkg::apb_lat_addr;
                    pwdata   <= rand_bits(2);
                    apb_step = 1;
                end
            end
            1: begin
                penable  <= 1'b1;
                apb_step = 2;
            end
            default: begin
                psel     <= 1'b0;
                penable  <= 1'b0;
                apb_step = 0;
            end
        endcase
    endtask

    task automatic finish_run();
        $display("transfers %0d, value errors %0d, protocol errors %0d, timeouts %0d",
                 n_xfer, value_errors, proto_errors, timeouts);
        if (value_errors + proto_errors + timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    initial begin
        resetn      = 1'b0;
        flush       = 1'b0;
        excep_entry = '0;
        out_ready   = 1'b0;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        exp_pc      = '0;
        repeat (reset_cycles) @(posedge clk);
        resetn <= 1'b1;
        load_and_verify();
        @(posedge clk);
        flush       <= 1'b1;  // fetch starts at reset_pc
        excep_entry <= fetch_pkg::reset_pc;
        out_ready   <= 1'b1;
        while (n_xfer < n_items) begin
            @(posedge clk);
            check_cycle();
            drive_inputs();
        end
        finish_run();
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        timeouts++;
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        finish_run();
    end

endmodule
